/* Makefile */
# Verilator build and run for the MCI subordinate testbench

VERILATOR ?= verilator
TOP       ?= tb_mci_sub
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* mci_pkg.sv */
// ======================================================================
// MCI subordinate shared definitions
// Bus widths, region codes, the two-way address union and the
// register map constants used by decode and both targets
// ======================================================================
`default_nettype none

package mci_pkg;

    // Bus widths
    localparam int MCI_ADDR_WIDTH = 32;
    localparam int MCI_DATA_WIDTH = 32;
    localparam int MCI_USER_WIDTH = 32;
    localparam int MCI_STRB_WIDTH = MCI_DATA_WIDTH / 8;

    typedef logic [MCI_ADDR_WIDTH-1:0] mci_addr_t;
    typedef logic [MCI_DATA_WIDTH-1:0] mci_data_t;
    typedef logic [MCI_STRB_WIDTH-1:0] mci_strb_t;
    typedef logic [MCI_USER_WIDTH-1:0] mci_user_t;

    // Target region of a request
    typedef enum logic [1:0] {
        REGION_REG  = 2'd0,
        REGION_SRAM = 2'd1,
        REGION_NONE = 2'd3
    } mci_region_e;

    // Register map, 16-byte window with privileged upper half
    localparam int                REG_IDX_WIDTH  = 2;
    localparam int                NUM_PRIV_REGS  = 2;
    localparam logic [15:0]       REG_BASE       = 16'h0000;
    localparam logic [15:0]       SRAM_BASE      = 16'h0001;
    localparam logic [REG_IDX_WIDTH-1:0] PRIV_REG_FIRST =
        REG_IDX_WIDTH'((2 ** REG_IDX_WIDTH) - NUM_PRIV_REGS);

    // Address as seen by the register block
    typedef struct packed {
        logic [15:0]              base;
        logic [11:0]              rsvd;
        logic [REG_IDX_WIDTH-1:0] reg_idx;
        logic [1:0]               byte_off;
    } mci_reg_addr_t;

    // Address as seen by the SRAM
    typedef struct packed {
        logic [15:0] base;
        logic [13:0] word_idx;
        logic [1:0]  byte_off;
    } mci_sram_addr_t;

    // Same address word, two decodings
    typedef union packed {
        mci_reg_addr_t  reg_view;
        mci_sram_addr_t sram_view;
    } mci_addr_u;

endpackage

`default_nettype wire

/* mci_reg_exec.sv */
// ======================================================================
// MCI register block target
// Small bank of 32-bit registers, byte-writable under strobes,
// with a registered read one cycle after select
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module mci_reg_exec
    import mci_pkg::*;
#(
    parameter int NUM_REGS = 4
) (
    input  logic      clk,
    input  logic      rst,

    // From decode
    input  logic      reg_sel,
    input  logic      exec_write,
    input  mci_addr_u exec_addr,
    input  mci_data_t exec_wdata,
    input  mci_strb_t exec_wstrb,

    // To result stage
    output mci_data_t reg_rdata
);

    mci_data_t                regs [NUM_REGS];
    logic [REG_IDX_WIDTH-1:0] reg_idx;
    logic                     idx_ok;
    logic                     wr_en;
    logic                     rd_en;

    // Register view of the address word
    assign reg_idx = exec_addr.reg_view.reg_idx;

    // Index beyond the bank is ignored
    assign idx_ok = int'(reg_idx) < NUM_REGS;

    assign wr_en = reg_sel && exec_write && idx_ok;
    assign rd_en = reg_sel && !exec_write;

    // Register bank
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            // Byte lanes merged under strobes
            for (int b = 0; b < MCI_STRB_WIDTH; b++) begin
                if (exec_wstrb[b]) begin
                    regs[reg_idx][b*8 +: 8] <= exec_wdata[b*8 +: 8];
                end
            end
        end
    end

    // Read data lands the cycle after select
    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (idx_ok) begin
                reg_rdata <= regs[reg_idx];
            end else begin
                reg_rdata <= '0;
            end
        end
    end

    // Decode never selects a register outside the bank
    reg_idx_range_a: assert property (@(posedge clk) disable iff (rst)
        reg_sel |-> idx_ok);

endmodule

`default_nettype wire

/* mci_req_decode.sv */
// ======================================================================
// MCI subordinate request decode
// Classifies each request into register, SRAM or unmapped space,
// enforces the privileged register write rule and flags privileged
// requesters, all registered one cycle ahead of the targets
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module mci_req_decode
    import mci_pkg::*;
#(
    parameter int SRAM_DEPTH = 256
) (
    input  logic      clk,
    input  logic      rst,

    // Incoming simplex request
    input  logic      req_dv,
    input  mci_addr_t req_addr,
    input  logic      req_write,
    input  mci_user_t req_user,
    input  mci_data_t req_wdata,
    input  mci_strb_t req_wstrb,

    // Privileged user straps
    input  mci_user_t strap_config_user,
    input  mci_user_t strap_lsu_user,

    // Execute stage
    output logic      exec_valid,
    output logic      reg_sel,
    output logic      sram_sel,
    output logic      exec_err,
    output logic      exec_write,
    output mci_addr_u exec_addr,
    output mci_data_t exec_wdata,
    output mci_strb_t exec_wstrb,

    // Privileged requester flags
    output logic      config_req,
    output logic      lsu_req
);

    // One extra bit so a full 14-bit index range still compares
    localparam logic [14:0] SRAM_WORDS = 15'(SRAM_DEPTH);

    mci_addr_u   req_addr_u;
    mci_region_e region;
    logic        priv_wr_err;
    logic        req_err;

    assign req_addr_u = req_addr;

    // Region from the union views
    always_comb begin
        region = REGION_NONE;
        if (req_addr_u.reg_view.base == REG_BASE && req_addr_u.reg_view.rsvd == '0) begin
            region = REGION_REG;
        end else if (req_addr_u.sram_view.base == SRAM_BASE &&
                     {1'b0, req_addr_u.sram_view.word_idx} < SRAM_WORDS) begin
            region = REGION_SRAM;
        end
    end

    // Upper register pair writable by the config user only, reads open
    assign priv_wr_err = (region == REGION_REG) && req_write &&
                         (req_addr_u.reg_view.reg_idx >= PRIV_REG_FIRST) &&
                         (req_user != strap_config_user);

    assign req_err = (region == REGION_NONE) || priv_wr_err;

    // Control, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            exec_valid <= 1'b0;
            reg_sel    <= 1'b0;
            sram_sel   <= 1'b0;
            exec_err   <= 1'b0;
            exec_write <= 1'b0;
            config_req <= 1'b0;
            lsu_req    <= 1'b0;
        end else begin
            exec_valid <= req_dv;
            reg_sel    <= req_dv && (region == REGION_REG) && !priv_wr_err;
            sram_sel   <= req_dv && (region == REGION_SRAM);
            exec_err   <= req_dv && req_err;
            exec_write <= req_dv && req_write;
            config_req <= req_dv && (req_user == strap_config_user);
            lsu_req    <= req_dv && (req_user == strap_lsu_user);
        end
    end

    // Payload, captured with each request
    always_ff @(posedge clk) begin
        if (req_dv) begin
            exec_addr  <= req_addr_u;
            exec_wdata <= req_wdata;
            exec_wstrb <= req_wstrb;
        end
    end

    // At most one target per request
    sel_onehot_a: assert property (@(posedge clk) disable iff (rst)
        !(reg_sel && sram_sel));

    // Rejected requests reach no target
    err_no_sel_a: assert property (@(posedge clk) disable iff (rst)
        exec_err |-> !(reg_sel || sram_sel));

endmodule

`default_nettype wire

/* mci_resp_mux.sv */
// ======================================================================
// MCI response stage
// Delays execute control one cycle to meet the target read data,
// steers the selected target's data and pulses the response
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module mci_resp_mux
    import mci_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Execute control from decode
    input  logic      exec_valid,
    input  logic      reg_sel,
    input  logic      sram_sel,
    input  logic      exec_err,
    input  logic      exec_write,

    // Target read data
    input  mci_data_t reg_rdata,
    input  mci_data_t sram_rdata,

    // Response
    output logic      resp_dv,
    output mci_data_t resp_rdata,
    output logic      resp_err
);

    logic reg_sel_q;
    logic sram_sel_q;
    logic write_q;

    // Control aligned with target data
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_dv    <= 1'b0;
            resp_err   <= 1'b0;
            reg_sel_q  <= 1'b0;
            sram_sel_q <= 1'b0;
            write_q    <= 1'b0;
        end else begin
            resp_dv    <= exec_valid;
            resp_err   <= exec_valid && exec_err;
            reg_sel_q  <= reg_sel;
            sram_sel_q <= sram_sel;
            write_q    <= exec_write;
        end
    end

    // Zero data on writes and errors
    always_comb begin
        resp_rdata = '0;
        if (!write_q && !resp_err) begin
            if (reg_sel_q) begin
                resp_rdata = reg_rdata;
            end else if (sram_sel_q) begin
                resp_rdata = sram_rdata;
            end
        end
    end

    // Target data only reaches a valid error-free response
    sel_ok_resp_a: assert property (@(posedge clk) disable iff (rst)
        (reg_sel_q || sram_sel_q) |-> (resp_dv && !resp_err));

endmodule

`default_nettype wire

/* mci_sram_exec.sv */
// ======================================================================
// MCI SRAM target
// Single-port word array, byte-strobed write and registered read,
// addressed through the SRAM view of the address word
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module mci_sram_exec
    import mci_pkg::*;
#(
    parameter int SRAM_DEPTH = 256
) (
    input  logic      clk,

    // From decode
    input  logic      sram_sel,
    input  logic      exec_write,
    input  mci_addr_u exec_addr,
    input  mci_data_t exec_wdata,
    input  mci_strb_t exec_wstrb,

    // To result stage
    output mci_data_t sram_rdata
);

    localparam int IDX_WIDTH = (SRAM_DEPTH > 1) ? $clog2(SRAM_DEPTH) : 1;

    // Contents not reset
    mci_data_t            mem [SRAM_DEPTH];
    logic [IDX_WIDTH-1:0] word_idx;

    // Decode has already bounded the index to the array depth
    assign word_idx = exec_addr.sram_view.word_idx[IDX_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (sram_sel) begin
            if (exec_write) begin
                // Write merges enabled byte lanes only
                for (int b = 0; b < MCI_STRB_WIDTH; b++) begin
                    if (exec_wstrb[b]) begin
                        mem[word_idx][b*8 +: 8] <= exec_wdata[b*8 +: 8];
                    end
                end
            end else begin
                // Registered read
                sram_rdata <= mem[word_idx];
            end
        end
    end

endmodule

`default_nettype wire

/* mci_sub_top.sv */
// ======================================================================
// MCI subordinate front end top level
// Decode, register block, SRAM and response stage, with a fixed
// two-cycle request to response latency
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module mci_sub_top
    import mci_pkg::*;
#(
    parameter int SRAM_DEPTH = 256,
    parameter int NUM_REGS   = 4
) (
    input  logic      clk,
    input  logic      rst,

    // Simplex request
    input  logic      req_dv,
    input  mci_addr_t req_addr,
    input  logic      req_write,
    input  mci_user_t req_user,
    input  mci_data_t req_wdata,
    input  mci_strb_t req_wstrb,

    // Privileged user straps, static
    input  mci_user_t strap_config_user,
    input  mci_user_t strap_lsu_user,

    // Response
    output logic      resp_dv,
    output mci_data_t resp_rdata,
    output logic      resp_err,

    // Privileged requests
    output logic      config_req,
    output logic      lsu_req
);

    // Decode to targets and result stage
    logic      exec_valid;
    logic      reg_sel;
    logic      sram_sel;
    logic      exec_err;
    logic      exec_write;
    mci_addr_u exec_addr;
    mci_data_t exec_wdata;
    mci_strb_t exec_wstrb;

    // Target read data
    mci_data_t reg_rdata;
    mci_data_t sram_rdata;

    mci_req_decode #(
        .SRAM_DEPTH (SRAM_DEPTH)
    ) i_mci_req_decode (
        .clk,
        .rst,
        .req_dv,
        .req_addr,
        .req_write,
        .req_user,
        .req_wdata,
        .req_wstrb,
        .strap_config_user,
        .strap_lsu_user,
        .exec_valid,
        .reg_sel,
        .sram_sel,
        .exec_err,
        .exec_write,
        .exec_addr,
        .exec_wdata,
        .exec_wstrb,
        .config_req,
        .lsu_req
    );

    mci_reg_exec #(
        .NUM_REGS (NUM_REGS)
    ) i_mci_reg_exec (
        .clk,
        .rst,
        .reg_sel,
        .exec_write,
        .exec_addr,
        .exec_wdata,
        .exec_wstrb,
        .reg_rdata
    );

    mci_sram_exec #(
        .SRAM_DEPTH (SRAM_DEPTH)
    ) i_mci_sram_exec (
        .clk,
        .sram_sel,
        .exec_write,
        .exec_addr,
        .exec_wdata,
        .exec_wstrb,
        .sram_rdata
    );

    mci_resp_mux i_mci_resp_mux (
        .clk,
        .rst,
        .exec_valid,
        .reg_sel,
        .sram_sel,
        .exec_err,
        .exec_write,
        .reg_rdata,
        .sram_rdata,
        .resp_dv,
        .resp_rdata,
        .resp_err
    );

endmodule

`default_nettype wire

/* mci_testdata.txt */
# Columns, all hex: write addr user wdata wstrb exp_rdata exp_err exp_config exp_lsu
# Straps: config user 0000C0F1, lsu user 000015A0, any other user is unprivileged
# SRAM full and partial strobes
1 00010000 00000777 DEADBEEF F 00000000 0 0 0
0 00010000 00000777 00000000 0 DEADBEEF 0 0 0
1 00010000 00000777 11223344 5 00000000 0 0 0
0 00010000 00000777 00000000 0 DE22BE44 0 0 0
1 00010004 0000C0F1 12345678 F 00000000 0 1 0
1 00010004 0000C0F1 AABBCCDD C 00000000 0 1 0
0 00010006 000015A0 00000000 0 AABB5678 0 0 1
1 000103FC 000015A0 A5A55A5A F 00000000 0 0 1
0 000103FC 0000C0F1 00000000 0 A5A55A5A 0 1 0
# Open registers 0 and 1
1 00000000 00000777 11111111 F 00000000 0 0 0
0 00000000 000015A0 00000000 0 11111111 0 0 1
1 00000004 00000777 CAFEF00D F 00000000 0 0 0
1 00000004 000015A0 0000AB00 2 00000000 0 0 1
0 00000004 00000777 00000000 0 CAFEAB0D 0 0 0
# Privileged registers 2 and 3
1 00000008 0000C0F1 0BADF00D F 00000000 0 1 0
0 00000008 00000777 00000000 0 0BADF00D 0 0 0
1 00000008 00000777 12345678 F 00000000 1 0 0
1 00000008 000015A0 FFFFFFFF F 00000000 1 0 1
0 00000008 000015A0 00000000 0 0BADF00D 0 0 1
1 0000000C 0000C0F1 5555AAAA F 00000000 0 1 0
1 0000000C 0000C0F1 77000000 8 00000000 0 1 0
1 0000000C 000015A0 00000000 F 00000000 1 0 1
0 0000000C 00000777 00000000 0 7755AAAA 0 0 0
# Unmapped space and SRAM words beyond the depth
0 00010400 00000777 00000000 0 00000000 1 0 0
1 00010400 0000C0F1 12345678 F 00000000 1 1 0
0 00020000 000015A0 00000000 0 00000000 1 0 1
1 00000010 00000777 87654321 F 00000000 1 0 0
0 FFFF0008 0000C0F1 00000000 0 00000000 1 1 0
0 00000014 00000777 00000000 0 00000000 1 0 0
# Targets untouched by the rejected writes
0 00010000 00000777 00000000 0 DE22BE44 0 0 0
0 00000008 0000C0F1 00000000 0 0BADF00D 0 1 0
0 00000000 00000777 00000000 0 11111111 0 0 0

/* sim.f */
mci_pkg.sv
mci_req_decode.sv
mci_reg_exec.sv
mci_sram_exec.sv
mci_resp_mux.sv
mci_sub_top.sv
tb_mci_sub.sv

/* tb_mci_sub.sv */
// ======================================================================
// MCI subordinate front end testbench
// Replays request vectors from the data file twice, once with random
// idle gaps and once back to back, and checks responses and flags
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module tb_mci_sub
    import mci_pkg::*;
;

    localparam string     TESTDATA_FILE = "mci_testdata.txt";
    localparam int        RESP_TIMEOUT  = 10;
    localparam mci_user_t CFG_USER      = 32'h0000_C0F1;
    localparam mci_user_t LSU_USER      = 32'h0000_15A0;

    // One request line with its expected results
    typedef struct {
        logic      write;
        mci_addr_t addr;
        mci_user_t user;
        mci_data_t wdata;
        mci_strb_t wstrb;
        mci_data_t exp_rdata;
        logic      exp_err;
        logic      exp_cfg;
        logic      exp_lsu;
    } req_rec_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      req_dv;
    mci_addr_t req_addr;
    logic      req_write;
    mci_user_t req_user;
    mci_data_t req_wdata;
    mci_strb_t req_wstrb;
    mci_user_t strap_config_user;
    mci_user_t strap_lsu_user;
    logic      resp_dv;
    mci_data_t resp_rdata;
    logic      resp_err;
    logic      config_req;
    logic      lsu_req;

    req_rec_t recs[$];
    req_rec_t resp_q[$];

    // Expected flag and strobe pipeline, fed from the driven stimulus
    logic drv_cfg = 1'b0;
    logic drv_lsu = 1'b0;
    logic cfg_exp = 1'b0;
    logic lsu_exp = 1'b0;
    logic dv_exp1 = 1'b0;
    logic dv_exp2 = 1'b0;

    int data_errors  = 0;
    int err_errors   = 0;
    int flag_errors  = 0;
    int other_errors = 0;

    mci_sub_top #(
        .SRAM_DEPTH (256),
        .NUM_REGS   (4)
    ) mci_sub_top_i (
        .clk,
        .rst,
        .req_dv,
        .req_addr,
        .req_write,
        .req_user,
        .req_wdata,
        .req_wstrb,
        .strap_config_user,
        .strap_lsu_user,
        .resp_dv,
        .resp_rdata,
        .resp_err,
        .config_req,
        .lsu_req
    );

    // 100 ns clock
    always #50 clk = ~clk;

    task automatic check_data(input mci_data_t got, input mci_data_t exp);
        if (got !== exp) begin
            data_errors++;
            $display("CHECK FAILED t=%0t resp_rdata got=%h exp=%h", $time, got, exp);
        end
    endtask

    task automatic check_err(input logic got, input logic exp);
        if (got !== exp) begin
            err_errors++;
            $display("CHECK FAILED t=%0t resp_err got=%b exp=%b", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("CHECK FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    // Flags one cycle after the request, resp_dv two cycles after
    always @(posedge clk) begin
        cfg_exp <= drv_cfg;
        lsu_exp <= drv_lsu;
        dv_exp1 <= req_dv;
        dv_exp2 <= dv_exp1;
    end

    // Sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        check_flag("config_req", config_req, cfg_exp);
        check_flag("lsu_req", lsu_req, lsu_exp);
        check_flag("resp_dv", resp_dv, dv_exp2);
    end

    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] f_write;
        logic [31:0] f_addr;
        logic [31:0] f_user;
        logic [31:0] f_wdata;
        logic [31:0] f_wstrb;
        logic [31:0] f_rdata;
        logic [31:0] f_err;
        logic [31:0] f_cfg;
        logic [31:0] f_lsu;
        req_rec_t    rec;
        fd = $fopen(TESTDATA_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("ERROR: could not open the test data file %s", TESTDATA_FILE);
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                // Skip comments and blank lines
                if (code > 0 && line.len() > 0 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_write, f_addr,
                                   f_user, f_wdata, f_wstrb, f_rdata, f_err, f_cfg, f_lsu);
                    if (code == 9) begin
                        rec.write     = f_write[0];
                        rec.addr      = f_addr;
                        rec.user      = f_user;
                        rec.wdata     = f_wdata;
                        rec.wstrb     = f_wstrb[MCI_STRB_WIDTH-1:0];
                        rec.exp_rdata = f_rdata;
                        rec.exp_err   = f_err[0];
                        rec.exp_cfg   = f_cfg[0];
                        rec.exp_lsu   = f_lsu[0];
                        recs.push_back(rec);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_request(input req_rec_t rec);
        @(posedge clk);
        req_dv    <= 1'b1;
        req_write <= rec.write;
        req_addr  <= rec.addr;
        req_user  <= rec.user;
        req_wdata <= rec.wdata;
        req_wstrb <= rec.wstrb;
        drv_cfg   <= rec.exp_cfg;
        drv_lsu   <= rec.exp_lsu;
        resp_q.push_back(rec);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        req_dv    <= 1'b0;
        req_write <= 1'b0;
        drv_cfg   <= 1'b0;
        drv_lsu   <= 1'b0;
    endtask

    // One pass over all vectors, gaps of 0 to 3 cycles when asked
    task automatic run_vectors(input bit random_gaps);
        int unsigned gap;
        for (int i = 0; i < recs.size(); i++) begin
            drive_request(recs[i]);
            gap = random_gaps ? ($urandom % 4) : 32'd0;
            for (int unsigned g = 0; g < gap; g++) begin
                drive_idle();
            end
        end
        drive_idle();
    endtask

    task automatic drive_all_passes();
        run_vectors(1'b1);
        // Second pass keeps write then read on consecutive cycles
        run_vectors(1'b0);
    endtask

    task automatic collect_responses(input int total);
        req_rec_t exp;
        int       waited;
        bit       abort;
        abort = 1'b0;
        for (int n = 0; n < total && !abort; n++) begin
            waited = 0;
            @(negedge clk);
            while (!resp_dv && waited < RESP_TIMEOUT) begin
                waited++;
                @(negedge clk);
            end
            if (!resp_dv) begin
                other_errors++;
                abort = 1'b1;
                $display("ERROR: no response within %0d cycles at %0t", RESP_TIMEOUT, $time);
            end else if (resp_q.size() == 0) begin
                other_errors++;
                $display("ERROR: response at %0t with no request outstanding", $time);
            end else begin
                exp = resp_q.pop_front();
                check_data(resp_rdata, exp.exp_rdata);
                check_err(resp_err, exp.exp_err);
            end
        end
    endtask

    initial begin
        int total_errors;
        void'($urandom(32'h2764_4329));
        rst               = 1'b1;
        req_dv            = 1'b0;
        req_addr          = '0;
        req_write         = 1'b0;
        req_user          = '0;
        req_wdata         = '0;
        req_wstrb         = '0;
        strap_config_user = CFG_USER;
        strap_lsu_user    = LSU_USER;
        load_vectors();
        if (recs.size() == 0) begin
            other_errors++;
            $display("ERROR: no request vectors were loaded");
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (recs.size() > 0) begin
            fork
                drive_all_passes();
                collect_responses(2 * recs.size());
            join
        end
        // Let the last flag checks run
        repeat (4) @(posedge clk);
        total_errors = data_errors + err_errors + flag_errors + other_errors;
        $display("Error counts: data %0d, resp_err %0d, flags %0d, other %0d",
                 data_errors, err_errors, flag_errors, other_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
